// File: list.f
logic/fadd_pkg.sv
logic/fadd_unpack_align.sv
logic/fadd_far_adder.sv
logic/fadd_close_path.sv
logic/fadd_round.sv
logic/fadd_pack.sv
logic/fadd_top.sv
tests/fadd_tb.sv

// File: logic/fadd_close_path.sv
// Close path subtractor with leading zero count and normalizing left shift
`timescale 1ns/1ns
`default_nettype none

module fadd_close_path (
  input  wire fadd_pkg::fadd_ex1_t ex1_q,
  output fadd_pkg::fsig_t          close_sig,
  output fadd_pkg::flzc_t          close_lzc,
  output logic                     close_zero
);

  fadd_pkg::fwide_t diff;
  fadd_pkg::fsig_t  diff_field;
  fadd_pkg::fsig_t  norm;

  // Exponents differ by at most one, so no bit reaches sticky
  assign diff = ex1_q.big_sig - ex1_q.small_sig_aligned;

  // Hidden-one position down to the guard bit
  assign diff_field = diff[fadd_pkg::wide_w-2:2];

  // Priority encoder, the highest set bit wins
  always_comb begin
    close_lzc = '0;
    for (int i = 0; i <= fadd_pkg::sig_w; i++) begin
      if (diff_field[i]) begin
        close_lzc = fadd_pkg::flzc_t'(fadd_pkg::sig_w - i);
      end
    end
  end

  assign norm = diff_field << close_lzc;

  // After a shift of one or more the bottom bit is always zero
  assign close_sig  = {1'b0, norm[fadd_pkg::sig_w:1]};
  assign close_zero = ~|diff_field;

endmodule

`default_nettype wire

// File: logic/fadd_far_adder.sv
// Far path adder that forms sum, difference and their round-up copies in parallel
`timescale 1ns/1ns
`default_nettype none

module fadd_far_adder (
  input  wire fadd_pkg::fadd_ex1_t ex1_q,
  output fadd_pkg::fwide_t         add_r,
  output fadd_pkg::fwide_t         add_inc1_r,
  output fadd_pkg::fwide_t         add_inc2_r,
  output fadd_pkg::fwide_t         sub_r,
  output fadd_pkg::fwide_t         sub_inc1_r,
  output fadd_pkg::fwide_t         sub_inc2_r,
  output fadd_pkg::fadd_path_t     path
);

  // Round-up weights at each candidate lsb position
  localparam fadd_pkg::fwide_t lsb_bit2 = fadd_pkg::fwide_t'(4);
  localparam fadd_pkg::fwide_t lsb_bit3 = fadd_pkg::fwide_t'(8);
  localparam fadd_pkg::fwide_t lsb_bit4 = fadd_pkg::fwide_t'(16);

  logic add_carry;
  logic sub_norm;

  // Effective add
  assign add_r      = ex1_q.big_sig + ex1_q.small_sig_aligned;
  assign add_inc1_r = add_r + lsb_bit3;
  assign add_inc2_r = add_r + lsb_bit4;

  // Effective subtract, big operand is never below the small one
  assign sub_r      = ex1_q.big_sig - ex1_q.small_sig_aligned;
  assign sub_inc1_r = sub_r + lsb_bit2;
  assign sub_inc2_r = sub_r + lsb_bit3;

  assign add_carry = add_r[fadd_pkg::wide_w-1];
  assign sub_norm  = sub_r[fadd_pkg::wide_w-2];

  // A far subtract loses at most one bit
  // Close operands that did not cancel still round on the far path
  always_comb begin
    path          = '0;
    path.add1xxxx = ~ex1_q.eff_sub & add_carry;
    path.add01xxx = ~ex1_q.eff_sub & ~add_carry;
    path.sub01xxx = ex1_q.eff_sub & sub_norm;
    path.sub001xx = ex1_q.eff_sub & ~sub_norm & ~ex1_q.close_sel;
    path.close    = ex1_q.eff_sub & ~sub_norm & ex1_q.close_sel;
  end

endmodule

`default_nettype wire

// File: logic/fadd_pack.sv
// Adder ex3 stage that fixes the exponent and registers the binary64 result
`timescale 1ns/1ns
`default_nettype none

module fadd_pack (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire fadd_pkg::fadd_ex2_t ex2_d,
  output logic                     out_vld,
  output fadd_pkg::fp64_t          out_rslt,
  output logic                     out_nx
);

  fadd_pkg::fexp_t exp_adj;
  fadd_pkg::fexp_t exp_res;
  fadd_pkg::fp64_t rslt_d;

  // Exponent follows where the leading one landed
  always_comb begin
    exp_adj = ex2_d.exp_big;
    if (ex2_d.path.add1xxxx) begin
      exp_adj = ex2_d.exp_big + 1'b1;
    end else if (ex2_d.path.sub001xx) begin
      exp_adj = ex2_d.exp_big - 1'b1;
    end else if (ex2_d.path.close) begin
      exp_adj = ex2_d.exp_big - fadd_pkg::fexp_t'(ex2_d.lzc);
    end
    // Rounding into the next binade
    exp_res = exp_adj + fadd_pkg::fexp_t'(ex2_d.rnd_sig[fadd_pkg::sig_w]);
  end

  always_comb begin
    if (ex2_d.zero) begin
      // x - x is +0 except when rounding down
      rslt_d = {ex2_d.rm == fadd_pkg::rdn, 63'd0};
    end else begin
      rslt_d = {ex2_d.sign, exp_res[fadd_pkg::exp_w-1:0], ex2_d.rnd_sig[fadd_pkg::man_w-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= ex2_d.vld;
    end
  end

  always_ff @(posedge clk) begin
    out_rslt <= rslt_d;
    out_nx   <= ex2_d.nx;
  end

endmodule

`default_nettype wire

// File: logic/fadd_pkg.sv
// Binary64 adder shared widths, vector types, rounding modes and pipeline bundles
`default_nettype none

package fadd_pkg;

  localparam int exp_w  = 11;
  localparam int man_w  = 52;
  localparam int sig_w  = 53;
  // Carry, hidden one plus fraction, then guard, round and sticky
  localparam int wide_w = 57;
  localparam int lzc_w  = 6;

  typedef logic [63:0]       fp64_t;
  typedef logic [exp_w+1:0]  fexp_t;
  typedef logic [sig_w:0]    fsig_t;
  typedef logic [wide_w-1:0] fwide_t;
  typedef logic [lzc_w-1:0]  flzc_t;

  // RISC-V frm encoding
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_t;

  // One-hot normalization path
  typedef struct packed {
    logic add1xxxx;
    logic add01xxx;
    logic sub01xxx;
    logic sub001xx;
    logic close;
  } fadd_path_t;

  typedef struct packed {
    logic        vld;
    logic        sign;
    logic        eff_sub;
    fexp_t       exp_big;
    fwide_t      big_sig;
    fwide_t      small_sig_aligned;
    logic        close_sel;
    round_mode_t rm;
  } fadd_ex1_t;

  typedef struct packed {
    logic        vld;
    logic        sign;
    fexp_t       exp_big;
    fadd_path_t  path;
    fsig_t       rnd_sig;
    flzc_t       lzc;
    logic        zero;
    logic        nx;
    round_mode_t rm;
  } fadd_ex2_t;

endpackage

`default_nettype wire

// File: logic/fadd_round.sv
// Rounding select for the far paths and merge with the close path result
`timescale 1ns/1ns
`default_nettype none

module fadd_round (
  input  wire fadd_pkg::fadd_ex1_t  ex1_q,
  input  wire fadd_pkg::fwide_t     add_r,
  input  wire fadd_pkg::fwide_t     add_inc1_r,
  input  wire fadd_pkg::fwide_t     add_inc2_r,
  input  wire fadd_pkg::fwide_t     sub_r,
  input  wire fadd_pkg::fwide_t     sub_inc1_r,
  input  wire fadd_pkg::fwide_t     sub_inc2_r,
  input  wire fadd_pkg::fadd_path_t path,
  input  wire fadd_pkg::fsig_t      close_sig,
  input  wire fadd_pkg::flzc_t      close_lzc,
  input  wire                       close_zero,
  output fadd_pkg::fadd_ex2_t       ex2_d
);

  typedef logic [fadd_pkg::sig_w-1:0] field_t;

  logic            add1_g, add1_r, add1_s, add1_inc;
  logic            add0_g, add0_r, add0_s, add0_inc;
  logic            sub1_g, sub1_r, sub1_s, sub1_inc;
  logic            sub0_g, sub0_r, sub0_inc;
  field_t          add1_field, add0_field, sub1_field, sub0_field;
  fadd_pkg::fsig_t far_sig;
  logic            far_nx;

  function automatic logic rnd_inc(input fadd_pkg::round_mode_t rm, input logic sign,
                                   input logic l, input logic g, input logic r,
                                   input logic s);
    logic any;
    any = g | r | s;
    case (rm)
      fadd_pkg::rne: rnd_inc = g & (l | r | s);
      fadd_pkg::rdn: rnd_inc = sign & any;
      fadd_pkg::rup: rnd_inc = ~sign & any;
      fadd_pkg::rmm: rnd_inc = g;
      default:       rnd_inc = 1'b0;
    endcase
  endfunction

  // A rounding overflow wraps the field to zero and clears its top bit
  function automatic fadd_pkg::fsig_t with_carry(input field_t field);
    with_carry = {~field[fadd_pkg::sig_w-1], field};
  endfunction

  // Sum carried out, lsb at bit 4
  assign add1_g   = add_r[3];
  assign add1_r   = add_r[2];
  assign add1_s   = add_r[1] | add_r[0];
  assign add1_inc = rnd_inc(ex1_q.rm, ex1_q.sign, add_r[4], add1_g, add1_r, add1_s);

  // Sum without carry, lsb at bit 3
  assign add0_g   = add_r[2];
  assign add0_r   = add_r[1];
  assign add0_s   = add_r[0];
  assign add0_inc = rnd_inc(ex1_q.rm, ex1_q.sign, add_r[3], add0_g, add0_r, add0_s);

  // Difference still normalized, lsb at bit 3
  assign sub1_g   = sub_r[2];
  assign sub1_r   = sub_r[1];
  assign sub1_s   = sub_r[0];
  assign sub1_inc = rnd_inc(ex1_q.rm, ex1_q.sign, sub_r[3], sub1_g, sub1_r, sub1_s);

  // Difference shifted by one, bit 0 already holds the sticky
  assign sub0_g   = sub_r[1];
  assign sub0_r   = sub_r[0];
  assign sub0_inc = rnd_inc(ex1_q.rm, ex1_q.sign, sub_r[2], sub0_g, sub0_r, 1'b0);

  assign add1_field = add1_inc ? add_inc2_r[56:4] : add_r[56:4];
  assign add0_field = add0_inc ? add_inc1_r[55:3] : add_r[55:3];
  assign sub1_field = sub1_inc ? sub_inc2_r[55:3] : sub_r[55:3];
  assign sub0_field = sub0_inc ? sub_inc1_r[54:2] : sub_r[54:2];

  assign far_sig = {(fadd_pkg::sig_w+1){path.add1xxxx}} & with_carry(add1_field) |
                   {(fadd_pkg::sig_w+1){path.add01xxx}} & with_carry(add0_field) |
                   {(fadd_pkg::sig_w+1){path.sub01xxx}} & with_carry(sub1_field) |
                   {(fadd_pkg::sig_w+1){path.sub001xx}} & with_carry(sub0_field);

  // Close path is exact
  assign far_nx = path.add1xxxx & (add1_g | add1_r | add1_s) |
                  path.add01xxx & (add0_g | add0_r | add0_s) |
                  path.sub01xxx & (sub1_g | sub1_r | sub1_s) |
                  path.sub001xx & (sub0_g | sub0_r);

  always_comb begin
    ex2_d         = '0;
    ex2_d.vld     = ex1_q.vld;
    ex2_d.sign    = ex1_q.sign;
    ex2_d.exp_big = ex1_q.exp_big;
    ex2_d.path    = path;
    ex2_d.rnd_sig = path.close ? close_sig : far_sig;
    ex2_d.lzc     = close_lzc;
    ex2_d.zero    = path.close & close_zero;
    ex2_d.nx      = far_nx;
    ex2_d.rm      = ex1_q.rm;
  end

endmodule

`default_nettype wire

// File: logic/fadd_top.sv
// Two-stage pipelined binary64 add and subtract unit
`timescale 1ns/1ns
`default_nettype none

module fadd_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        in_vld,
  input  wire fadd_pkg::fp64_t       in_a,
  input  wire fadd_pkg::fp64_t       in_b,
  input  wire                        in_sub,
  input  wire fadd_pkg::round_mode_t in_rm,
  output wire                        out_vld,
  output wire fadd_pkg::fp64_t       out_rslt,
  output wire                        out_nx
);

  wire fadd_pkg::fadd_ex1_t  ex1_q;
  wire fadd_pkg::fwide_t     add_r;
  wire fadd_pkg::fwide_t     add_inc1_r;
  wire fadd_pkg::fwide_t     add_inc2_r;
  wire fadd_pkg::fwide_t     sub_r;
  wire fadd_pkg::fwide_t     sub_inc1_r;
  wire fadd_pkg::fwide_t     sub_inc2_r;
  wire fadd_pkg::fadd_path_t path;
  wire fadd_pkg::fsig_t      close_sig;
  wire fadd_pkg::flzc_t      close_lzc;
  wire                       close_zero;
  wire fadd_pkg::fadd_ex2_t  ex2_d;

  // ex1
  fadd_unpack_align u_unpack_align (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_vld (in_vld),
    .in_a   (in_a),
    .in_b   (in_b),
    .in_sub (in_sub),
    .in_rm  (in_rm),
    .ex1_q  (ex1_q)
  );

  // ex2 far and close paths run side by side
  fadd_far_adder u_far_adder (
    .ex1_q      (ex1_q),
    .add_r      (add_r),
    .add_inc1_r (add_inc1_r),
    .add_inc2_r (add_inc2_r),
    .sub_r      (sub_r),
    .sub_inc1_r (sub_inc1_r),
    .sub_inc2_r (sub_inc2_r),
    .path       (path)
  );

  fadd_close_path u_close_path (
    .ex1_q      (ex1_q),
    .close_sig  (close_sig),
    .close_lzc  (close_lzc),
    .close_zero (close_zero)
  );

  fadd_round u_round (
    .ex1_q      (ex1_q),
    .add_r      (add_r),
    .add_inc1_r (add_inc1_r),
    .add_inc2_r (add_inc2_r),
    .sub_r      (sub_r),
    .sub_inc1_r (sub_inc1_r),
    .sub_inc2_r (sub_inc2_r),
    .path       (path),
    .close_sig  (close_sig),
    .close_lzc  (close_lzc),
    .close_zero (close_zero),
    .ex2_d      (ex2_d)
  );

  // ex3
  fadd_pack u_pack (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex2_d    (ex2_d),
    .out_vld  (out_vld),
    .out_rslt (out_rslt),
    .out_nx   (out_nx)
  );

endmodule

`default_nettype wire

// File: logic/fadd_unpack_align.sv
// Adder ex1 stage that orders the operands by magnitude and aligns the smaller one
`timescale 1ns/1ns
`default_nettype none

module fadd_unpack_align (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    in_vld,
  input  wire fadd_pkg::fp64_t   in_a,
  input  wire fadd_pkg::fp64_t   in_b,
  input  wire                    in_sub,
  input  wire fadd_pkg::round_mode_t in_rm,
  output fadd_pkg::fadd_ex1_t    ex1_q
);

  logic                       sign_a;
  logic                       sign_b_eff;
  logic                       eff_sub;
  logic                       a_ge_b;
  fadd_pkg::fp64_t            big_op;
  fadd_pkg::fp64_t            small_op;
  logic                       big_sign;
  logic [fadd_pkg::exp_w-1:0] big_exp;
  logic [fadd_pkg::exp_w-1:0] small_exp;
  logic [fadd_pkg::exp_w-1:0] exp_diff;
  fadd_pkg::fwide_t           big_sig;
  fadd_pkg::fwide_t           small_sig;
  fadd_pkg::fwide_t           small_shift;
  fadd_pkg::fwide_t           lost_mask;
  logic                       sticky;
  fadd_pkg::fadd_ex1_t        ex1_d;

  // Subtraction flips the sign of b before the effective operation is known
  assign sign_a     = in_a[63];
  assign sign_b_eff = in_b[63] ^ in_sub;
  assign eff_sub    = sign_a ^ sign_b_eff;

  // Exponent and fraction compare as one unsigned magnitude
  assign a_ge_b = in_a[62:0] >= in_b[62:0];

  assign big_op   = a_ge_b ? in_a : in_b;
  assign small_op = a_ge_b ? in_b : in_a;
  assign big_sign = a_ge_b ? sign_a : sign_b_eff;

  assign big_exp   = big_op[fadd_pkg::man_w +: fadd_pkg::exp_w];
  assign small_exp = small_op[fadd_pkg::man_w +: fadd_pkg::exp_w];
  assign exp_diff  = big_exp - small_exp;

  // Operands are always normal, so the hidden one is set
  assign big_sig   = {1'b0, 1'b1, big_op[fadd_pkg::man_w-1:0], 3'b000};
  assign small_sig = {1'b0, 1'b1, small_op[fadd_pkg::man_w-1:0], 3'b000};

  // Shifts past the vector width leave only sticky
  assign small_shift = small_sig >> exp_diff;
  assign lost_mask   = ~({fadd_pkg::wide_w{1'b1}} << exp_diff);
  assign sticky      = |(small_sig & lost_mask);

  always_comb begin
    ex1_d                   = '0;
    ex1_d.vld               = in_vld;
    ex1_d.sign              = big_sign;
    ex1_d.eff_sub           = eff_sub;
    ex1_d.exp_big           = {2'b00, big_exp};
    ex1_d.big_sig           = big_sig;
    ex1_d.small_sig_aligned = {small_shift[fadd_pkg::wide_w-1:1], small_shift[0] | sticky};
    // Close path covers subtracts with exponents at most one apart
    ex1_d.close_sel         = eff_sub & ~|exp_diff[fadd_pkg::exp_w-1:1];
    ex1_d.rm                = in_rm;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex1_q.vld <= 1'b0;
    end else begin
      ex1_q <= ex1_d;
    end
  end

endmodule

`default_nettype wire

// File: tests/fadd_tb.sv
// Self-checking testbench for the pipelined binary64 adder, driven from a vector file
`timescale 1ns/1ns
`default_nettype none

module fadd_tb;

  localparam int num_vec   = 31;
  localparam int num_col   = 7;
  // Each vector takes at most three cycles with its idle gap
  localparam int limit_cyc = num_vec * 4 + 50;

  typedef struct packed {
    logic [7:0]      id;
    logic [31:0]     due;
    logic            nx;
    fadd_pkg::fp64_t rslt;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic                  in_vld;
  fadd_pkg::fp64_t       in_a;
  fadd_pkg::fp64_t       in_b;
  logic                  in_sub;
  fadd_pkg::round_mode_t in_rm;
  wire                   out_vld;
  wire fadd_pkg::fp64_t  out_rslt;
  wire                   out_nx;

  logic [63:0]  vec_mem [0:num_vec*num_col-1];
  expect_t      exp_q [$];
  expect_t      got;
  int unsigned  cyc = 0;
  int unsigned  lcg_state = 43910;
  int           val_errs = 0;
  int           oth_errs = 0;

  fadd_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (in_vld),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_sub   (in_sub),
    .in_rm    (in_rm),
    .out_vld  (out_vld),
    .out_rslt (out_rslt),
    .out_nx   (out_nx)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'd0:    test_name = "add_exact";
      8'd1:    test_name = "add_round";
      8'd2:    test_name = "add_carry";
      8'd3:    test_name = "far_sub";
      8'd4:    test_name = "close_sub";
      8'd5:    test_name = "zero";
      default: test_name = "unknown";
    endcase
  endfunction

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && out_vld) begin
      if (exp_q.size() == 0) begin
        $display("Output valid at cycle %0d with no operation in flight", cyc);
        oth_errs++;
      end else begin
        got = exp_q.pop_front();
        if (cyc != got.due) begin
          $display("Result for %s came at cycle %0d instead of cycle %0d",
                   test_name(got.id), cyc, got.due);
          oth_errs++;
        end
        if (out_rslt !== got.rslt) begin
          $display("error %s result expected %h actual %h",
                   test_name(got.id), got.rslt, out_rslt);
          val_errs++;
        end
        if (out_nx !== got.nx) begin
          $display("error %s nx expected %0b actual %0b", test_name(got.id), got.nx, out_nx);
          val_errs++;
        end
      end
    end
  end

  initial begin : stimulus
    int gap;
    int base;
    expect_t entry;
    rst_n  = 1'b0;
    in_vld = 1'b0;
    in_a   = '0;
    in_b   = '0;
    in_sub = 1'b0;
    in_rm  = fadd_pkg::rne;
    $readmemh("tests/fadd_testdata.hex", vec_mem);
    if ($isunknown(vec_mem[num_vec*num_col-1])) begin
      $display("Vector file is missing or shorter than %0d vectors", num_vec);
      oth_errs++;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle cycles where out_vld must stay low
    repeat (4) @(posedge clk);
    for (int i = 0; i < num_vec; i++) begin
      base = i * num_col;
      gap  = next_rand() % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
        in_vld = 1'b0;
      end
      @(posedge clk);
      #1;
      in_vld = 1'b1;
      in_rm  = fadd_pkg::round_mode_t'(vec_mem[base+1][2:0]);
      in_sub = vec_mem[base+2][0];
      in_a   = vec_mem[base+3];
      in_b   = vec_mem[base+4];
      entry.id   = vec_mem[base][7:0];
      entry.due  = cyc + 2;
      entry.nx   = vec_mem[base+6][0];
      entry.rslt = vec_mem[base+5];
      exp_q.push_back(entry);
    end
    @(posedge clk);
    #1;
    in_vld = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // A few more cycles to catch stray outputs
    repeat (3) @(posedge clk);
    $display("Checked %0d vectors: %0d value errors, %0d other errors",
             num_vec, val_errs, oth_errs);
    if (val_errs == 0 && oth_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    repeat (limit_cyc) @(posedge clk);
    $display("Run stopped after %0d cycles with %0d results still pending",
             limit_cyc, exp_q.size());
    $display("Checked %0d vectors: %0d value errors, %0d other errors",
             num_vec, val_errs, oth_errs);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/fadd_testdata.hex
// Columns: test id, rounding mode, sub, operand a, operand b, expected result, expected nx
// Test ids: 0 add_exact, 1 add_round, 2 add_carry, 3 far_sub, 4 close_sub, 5 zero
00 0 0 3FF0000000000000 3FF0000000000000 4000000000000000 0
00 0 1 3FF0000000000000 BFF0000000000000 4000000000000000 0
01 0 0 3FF0000000000000 3CA0000000000000 3FF0000000000000 1
01 3 0 3FF0000000000000 3CA0000000000000 3FF0000000000001 1
01 4 0 3FF0000000000000 3CA0000000000000 3FF0000000000001 1
01 0 0 3FF0000000000001 3CA0000000000000 3FF0000000000002 1
01 2 0 BFF0000000000000 BCA0000000000000 BFF0000000000001 1
01 3 0 BFF0000000000000 BCA0000000000000 BFF0000000000000 1
01 3 0 3FF0000000000000 3C30000000000000 3FF0000000000001 1
01 0 0 3FB999999999999A 3FC999999999999A 3FD3333333333334 1
02 0 0 3FFFFFFFFFFFFFFF 3CA0000000000000 4000000000000000 1
02 1 0 3FFFFFFFFFFFFFFF 3CA0000000000000 3FFFFFFFFFFFFFFF 1
02 0 0 3FFFFFFFFFFFFFFF 3FF0000000000000 4008000000000000 1
03 0 1 4000000000000000 3CA0000000000000 4000000000000000 1
03 1 1 4000000000000000 3CA0000000000000 3FFFFFFFFFFFFFFF 1
03 2 1 4000000000000000 3C90000000000000 3FFFFFFFFFFFFFFF 1
03 0 1 4008000000000000 3CB0000000000000 4008000000000000 1
03 1 1 4008000000000000 3CB0000000000000 4007FFFFFFFFFFFF 1
03 2 0 C008000000000000 3CB0000000000000 C008000000000000 1
03 3 0 C008000000000000 3CB0000000000000 C007FFFFFFFFFFFF 1
03 0 1 3FF0000000000000 3C90000000000000 3FF0000000000000 1
03 2 1 3FF0000000000000 3C30000000000000 3FEFFFFFFFFFFFFF 1
03 0 1 400C000000000000 3FF0000000000000 4004000000000000 0
04 0 1 3FF8000000000000 3FF0000000000000 3FE0000000000000 0
04 0 1 4000000000000000 3FFFFFFFFFFFFFFF 3CB0000000000000 0
04 0 1 4000000000000000 3FF0000000000001 3FEFFFFFFFFFFFFE 0
04 2 0 BFF0000000000000 3FF8000000000000 3FE0000000000000 0
04 1 1 3FF0000000000000 3FF8000000000000 BFE0000000000000 0
05 0 1 3FF8000000000000 3FF8000000000000 0000000000000000 0
05 2 1 3FF8000000000000 3FF8000000000000 8000000000000000 0
05 3 0 C004000000000000 4004000000000000 0000000000000000 0
